/* project.f */
+incdir+logic
logic/ccu_mem_pkg.sv
logic/ccu_mem_ax_issuer.sv
logic/ccu_mem_wb_buffer.sv
logic/ccu_mem_port_merge.sv
logic/ccu_mem_unit.sv
test/tb_mem_model.sv
test/tb_ccu_mem_unit.sv

/* test/tb_ccu_mem_unit.sv */
`include "ccu_mem_settings.svh"

module tb_ccu_mem_unit import ccu_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 5;
    localparam int NUM_RANDOM  = 40;
    localparam int CYCLE_LIMIT = NUM_TESTS * 400;
    localparam int LINE_BYTES  = `CCU_LINE_WORDS * `CCU_DATA_W / 8;

    logic      clk, rst_n, cmd_valid, cmd_ready, cd_valid, cd_full, bp_en;
    mu_op_e    cmd_op;
    mem_req_t  cmd_req, core_req, mem_req;
    mem_resp_t core_resp, mem_resp;
    src_t      cmd_src;
    data_t     cd_data;

    mem_ax_t exp_aw[$], exp_ar[$];
    mem_w_t  exp_w[$], core_w_q[$];
    mem_r_t  exp_r[$], got_r[$];
    mem_id_t exp_b[$], got_b[$];
    data_t   snoop_q[$];
    integer  seed = 73807;
    int      errors = 0;
    int      failed = 0;
    int      cycles = 0;
    logic    core_w_pop = 1'b0;
    logic    order_chk = 1'b0;
    logic    wb_seen = 1'b0;
    mem_id_t last_wb_id;

    ccu_mem_unit DUT (
        .clk_i(clk), .rst_ni(rst_n), .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready),
        .cmd_op_i(cmd_op), .cmd_req_i(cmd_req), .cmd_src_i(cmd_src),
        .core_req_i(core_req), .core_resp_o(core_resp), .mem_req_o(mem_req),
        .mem_resp_i(mem_resp), .cd_data_i(cd_data), .cd_valid_i(cd_valid), .cd_full_o(cd_full)
    );

    tb_mem_model u_mem (
        .clk_i(clk), .rst_ni(rst_n), .bp_en_i(bp_en), .mem_req_i(mem_req), .mem_resp_o(mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected writeback AW covering a full aligned line under the responder ID
    function automatic mem_ax_t ref_wb_aw(mu_op_e op, mem_req_t req, src_t src);
        mem_ax_t base;
        mem_ax_t ax;
        base    = (op == OP_WB_WRITE) ? req.aw : req.ar;
        ax      = '0;
        ax.id   = {src, base.id[`CCU_CORE_ID_W-1:0]};
        ax.addr = base.addr & ~addr_t'(LINE_BYTES - 1);
        ax.len  = 8'(`CCU_LINE_WORDS - 1);
        ax.size = 3'd3;
        ax.wb   = 1'b1;
        return ax;
    endfunction

    function automatic data_t ref_r_data(addr_t addr, int beat);
        return {addr, 24'h00C0DE, 8'(beat)};
    endfunction

    function automatic mem_ax_t make_ax(int id, addr_t addr, int len);
        mem_ax_t ax;
        ax      = '0;
        ax.id   = mem_id_t'(id & 4'hf);
        ax.addr = addr;
        ax.len  = 8'(len);
        ax.size = 3'd3;
        return ax;
    endfunction

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic run_cmd(mu_op_e op, mem_ax_t ar, mem_ax_t aw, src_t src);
        mem_req_t req;
        mem_w_t   w;
        mem_r_t   r;
        req    = '0;
        req.ar = ar;
        req.aw = aw;
        if (op == OP_WB_READ || op == OP_WB_WRITE) begin
            exp_aw.push_back(ref_wb_aw(op, req, src));
            for (int i = 0; i < `CCU_LINE_WORDS; i++) begin
                w.data = {$random(seed), $random(seed)};
                w.strb = '1;
                w.last = (i == `CCU_LINE_WORDS - 1);
                snoop_q.push_back(w.data);
                exp_w.push_back(w);
            end
        end
        if (op == OP_WRITE || op == OP_WB_WRITE) begin
            exp_aw.push_back(aw);
            exp_b.push_back(aw.id);
            for (int i = 0; i <= int'(aw.len); i++) begin
                w.data = {$random(seed), $random(seed)};
                w.strb = 8'($random(seed));
                w.last = (i == int'(aw.len));
                core_w_q.push_back(w);
                exp_w.push_back(w);
            end
        end else begin
            exp_ar.push_back(ar);
            for (int i = 0; i <= int'(ar.len); i++) begin
                r.id   = ar.id;
                r.data = ref_r_data(ar.addr, i);
                r.resp = 2'b00;
                r.last = (i == int'(ar.len));
                exp_r.push_back(r);
            end
        end
        @(posedge clk);
        #10;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_req   = req;
        cmd_src   = src;
        do @(negedge clk); while (!cmd_ready);
        @(posedge clk);
        #10;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do @(negedge clk);
        while (!(cmd_ready && exp_aw.size() == 0 && exp_ar.size() == 0 && exp_w.size() == 0
                 && exp_r.size() == 0 && exp_b.size() == 0 && core_w_q.size() == 0
                 && snoop_q.size() == 0 && u_mem.b_owed == 0));
    endtask

    task automatic end_test(int num, string name, int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
            failed++;
        end
    endtask

    // Core W and snoop sender that holds snoop beats back while the FIFO is full
    initial begin
        forever begin
            @(posedge clk);
            #10;
            if (core_w_pop) void'(core_w_q.pop_front());
            core_w_pop       = 1'b0;
            core_req.w_valid = (core_w_q.size() != 0);
            core_req.w       = (core_w_q.size() != 0) ? core_w_q[0] : '0;
            cd_valid         = (snoop_q.size() != 0) && !cd_full;
            if (cd_valid) cd_data = snoop_q.pop_front();
        end
    end

    always @(negedge clk) begin
        if (core_req.w_valid && core_resp.w_ready) core_w_pop = 1'b1;
        if (core_resp.r_valid) got_r.push_back(core_resp.r);
        if (core_resp.b_valid) got_b.push_back(core_resp.b.id);
    end

    // Logs only change at the falling edge and are compared at the rising edge
    always @(posedge clk) begin : compare
        mem_ax_t ax;
        int      owed;
        while (u_mem.aw_log.size() != 0) begin
            ax   = u_mem.aw_log.pop_front();
            owed = u_mem.aw_owed_log.pop_front();
            if (exp_aw.size() == 0) begin
                $display("unexpected AW with address %h at memory", ax.addr);
                errors++;
            end else begin
                check_value("mem aw", ax, exp_aw.pop_front());
            end
            if (ax.wb) begin
                last_wb_id = ax.id;
                wb_seen    = 1'b1;
            end else if (order_chk && wb_seen && ax.id == last_wb_id && owed != 0) begin
                $display("core AW reached memory before the writeback B returned");
                errors++;
            end
        end
        while (u_mem.ar_log.size() != 0) begin
            if (order_chk && !wb_seen) begin
                $display("AR reached memory before the writeback AW");
                errors++;
            end
            if (exp_ar.size() == 0) begin
                $display("unexpected AR at memory");
                errors++;
                void'(u_mem.ar_log.pop_front());
            end else begin
                check_value("mem ar", u_mem.ar_log.pop_front(), exp_ar.pop_front());
            end
        end
        while (u_mem.w_log.size() != 0) begin
            if (exp_w.size() == 0) begin
                $display("unexpected W beat at memory");
                errors++;
                void'(u_mem.w_log.pop_front());
            end else begin
                check_value("mem w", u_mem.w_log.pop_front(), exp_w.pop_front());
            end
        end
        while (got_r.size() != 0) begin
            if (exp_r.size() == 0) begin
                $display("unexpected R beat at the core");
                errors++;
                void'(got_r.pop_front());
            end else begin
                check_value("core r", got_r.pop_front(), exp_r.pop_front());
            end
        end
        while (got_b.size() != 0) begin
            if (exp_b.size() == 0) begin
                $display("unexpected B at the core with ID %h", got_b.pop_front());
                errors++;
            end else begin
                check_value("core b id", got_b.pop_front(), exp_b.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin : main
        int e;
        rst_n     = 1'b0;
        bp_en     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_READ;
        cmd_req   = '0;
        cmd_src   = '0;
        core_req  = '0;
        core_req.b_ready = 1'b1;
        core_req.r_ready = 1'b1;
        cd_data   = '0;
        cd_valid  = 1'b0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_value("cmd_ready_o", cmd_ready, 1'b1);
        check_value("cd_full_o", cd_full, 1'b0);
        check_value("mem valids", {mem_req.ar_valid, mem_req.aw_valid, mem_req.w_valid}, 3'b0);

        e = errors;
        run_cmd(OP_READ, make_ax(3, 32'h1000_0040, 3), '0, 2'd1);
        wait_idle();
        end_test(1, "read forward", e);

        e = errors;
        order_chk = 1'b1;
        wb_seen   = 1'b0;
        run_cmd(OP_WB_READ, make_ax(5, 32'h2000_0068, 1), '0, 2'd2);
        wait_idle();
        order_chk = 1'b0;
        end_test(2, "writeback then read", e);

        e = errors;
        run_cmd(OP_WRITE, '0, make_ax(7, 32'h3000_0010, 2), 2'd1);
        wait_idle();
        end_test(3, "write forward", e);

        e = errors;
        order_chk = 1'b1;
        wb_seen   = 1'b0;
        run_cmd(OP_WB_WRITE, '0, make_ax(9, 32'h4000_0024, 1), 2'd0);
        wait_idle();
        order_chk = 1'b0;
        end_test(4, "writeback then write", e);

        e = errors;
        bp_en = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            run_cmd(mu_op_e'($random(seed) & 3),
                    make_ax($random(seed), addr_t'($random(seed)), $random(seed) & 3),
                    make_ax($random(seed), addr_t'($random(seed)), $random(seed) & 3),
                    src_t'($random(seed)));
        end
        wait_idle();
        end_test(5, "random back-pressure mix", e);

        $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

/* test/tb_mem_model.sv */
module tb_mem_model import ccu_mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      bp_en_i,
    input  mem_req_t  mem_req_i,
    output mem_resp_t mem_resp_o
);
    timeunit 1ns;
    timeprecision 1ps;

    integer  seed = 73807;
    mem_ax_t aw_log[$];
    int      aw_owed_log[$];
    mem_w_t  w_log[$];
    mem_ax_t ar_log[$];
    // IDs of accepted AWs still waiting for their W burst
    mem_id_t w_id_q[$];
    mem_b_t  b_q[$];
    mem_ax_t r_q[$];
    int      r_beat = 0;
    int      b_owed = 0;

    // Read data rule on the burst address and the beat index
    function automatic data_t read_word(addr_t addr, int beat);
        return {addr, 24'h00C0DE, 8'(beat)};
    endfunction

    function automatic logic pick_ready();
        if (!bp_en_i) return 1'b1;
        return ($random(seed) & 3) != 0;
    endfunction

    initial begin
        mem_resp_o = '0;
        forever begin
            @(posedge clk_i);
            #10;
            mem_resp_o.aw_ready = pick_ready();
            mem_resp_o.w_ready  = pick_ready();
            mem_resp_o.ar_ready = pick_ready();
            mem_resp_o.b_valid  = (b_q.size() != 0);
            mem_resp_o.b        = (b_q.size() != 0) ? b_q[0] : '0;
            mem_resp_o.r_valid  = (r_q.size() != 0);
            mem_resp_o.r        = '0;
            if (r_q.size() != 0) begin
                mem_resp_o.r.id   = r_q[0].id;
                mem_resp_o.r.data = read_word(r_q[0].addr, r_beat);
                mem_resp_o.r.last = (r_beat == int'(r_q[0].len));
            end
        end
    end

    // Handshakes are taken mid cycle where all signals are settled
    always @(negedge clk_i) begin : sample
        mem_b_t nb;
        if (rst_ni) begin
            if (mem_resp_o.b_valid && mem_req_i.b_ready) begin
                void'(b_q.pop_front());
                b_owed--;
            end
            if (mem_resp_o.r_valid && mem_req_i.r_ready) begin
                if (mem_resp_o.r.last) begin
                    void'(r_q.pop_front());
                    r_beat = 0;
                end else begin
                    r_beat++;
                end
            end
            if (mem_req_i.aw_valid && mem_resp_o.aw_ready) begin
                aw_log.push_back(mem_req_i.aw);
                aw_owed_log.push_back(b_owed);
                w_id_q.push_back(mem_req_i.aw.id);
                b_owed++;
            end
            if (mem_req_i.w_valid && mem_resp_o.w_ready) begin
                w_log.push_back(mem_req_i.w);
                if (mem_req_i.w.last) begin
                    nb.id   = w_id_q.pop_front();
                    nb.resp = 2'b00;
                    b_q.push_back(nb);
                end
            end
            if (mem_req_i.ar_valid && mem_resp_o.ar_ready) begin
                ar_log.push_back(mem_req_i.ar);
                r_q.push_back(mem_req_i.ar);
            end
        end
    end
endmodule

/* logic/ccu_mem_unit.sv */
module ccu_mem_unit import ccu_mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    input  mu_op_e    cmd_op_i,
    input  mem_req_t  cmd_req_i,
    input  src_t      cmd_src_i,

    input  mem_req_t  core_req_i,
    output mem_resp_t core_resp_o,

    output mem_req_t  mem_req_o,
    input  mem_resp_t mem_resp_i,

    input  data_t     cd_data_i,
    input  logic      cd_valid_i,
    output logic      cd_full_o
);

    mem_ax_t iss_ar, iss_aw;
    logic    iss_ar_valid, iss_aw_valid;
    logic    iss_ar_ready, iss_aw_ready;
    logic    wb_pending;
    mem_id_t wb_id;
    mem_w_t  buf_beat;
    logic    buf_valid, buf_ready;

    ccu_mem_ax_issuer u_issuer (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .cmd_op_i       (cmd_op_i),
        .cmd_req_i      (cmd_req_i),
        .cmd_src_i      (cmd_src_i),
        .iss_ar_o       (iss_ar),
        .iss_aw_o       (iss_aw),
        .iss_ar_valid_o (iss_ar_valid),
        .iss_aw_valid_o (iss_aw_valid),
        .iss_ar_ready_i (iss_ar_ready),
        .iss_aw_ready_i (iss_aw_ready),
        .wb_pending_i   (wb_pending),
        .wb_id_i        (wb_id)
    );

    ccu_mem_wb_buffer u_wb_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cd_data_i   (cd_data_i),
        .cd_valid_i  (cd_valid_i),
        .cd_full_o   (cd_full_o),
        .buf_beat_o  (buf_beat),
        .buf_valid_o (buf_valid),
        .buf_ready_i (buf_ready)
    );

    ccu_mem_port_merge u_port_merge (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .core_req_i     (core_req_i),
        .core_resp_o    (core_resp_o),
        .mem_req_o      (mem_req_o),
        .mem_resp_i     (mem_resp_i),
        .iss_ar_i       (iss_ar),
        .iss_aw_i       (iss_aw),
        .iss_ar_valid_i (iss_ar_valid),
        .iss_aw_valid_i (iss_aw_valid),
        .iss_ar_ready_o (iss_ar_ready),
        .iss_aw_ready_o (iss_aw_ready),
        .buf_beat_i     (buf_beat),
        .buf_valid_i    (buf_valid),
        .buf_ready_o    (buf_ready),
        .wb_pending_o   (wb_pending),
        .wb_id_o        (wb_id)
    );

endmodule

/* logic/ccu_mem_port_merge.sv */
module ccu_mem_port_merge import ccu_mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  mem_req_t  core_req_i,
    output mem_resp_t core_resp_o,

    output mem_req_t  mem_req_o,
    input  mem_resp_t mem_resp_i,

    input  mem_ax_t   iss_ar_i,
    input  mem_ax_t   iss_aw_i,
    input  logic      iss_ar_valid_i,
    input  logic      iss_aw_valid_i,
    output logic      iss_ar_ready_o,
    output logic      iss_aw_ready_o,

    input  mem_w_t    buf_beat_i,
    input  logic      buf_valid_i,
    output logic      buf_ready_o,

    output logic      wb_pending_o,
    output mem_id_t   wb_id_o
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_PASS,
        W_BUF
    } w_state_e;

    w_state_e w_state_q, w_state_d;
    logic     core_owed_q, core_owed_d;
    logic     wb_pending_q;
    mem_id_t  wb_id_q;

    logic aw_open;
    logic aw_hs;
    logic w_hs;
    logic wb_hit;

    // A new AW waits for the W burst in flight, except a core AW behind a buffer line
    assign aw_open = (w_state_q == W_IDLE) ||
                     ((w_state_q == W_BUF) && !iss_aw_i.wb && !core_owed_q);
    assign aw_hs   = iss_aw_valid_i && aw_open && mem_resp_i.aw_ready;
    assign wb_hit  = wb_pending_q && (mem_resp_i.b.id == wb_id_q);

    assign iss_ar_ready_o = mem_resp_i.ar_ready;
    assign iss_aw_ready_o = mem_resp_i.aw_ready && aw_open;

    always_comb begin
        mem_req_o          = '0;
        mem_req_o.ar       = iss_ar_i;
        mem_req_o.ar_valid = iss_ar_valid_i;
        mem_req_o.aw       = iss_aw_i;
        mem_req_o.aw_valid = iss_aw_valid_i && aw_open;
        mem_req_o.r_ready  = core_req_i.r_ready;
        mem_req_o.w        = core_req_i.w;

        core_resp_o         = '0;
        core_resp_o.r       = mem_resp_i.r;
        core_resp_o.r_valid = mem_resp_i.r_valid;
        core_resp_o.b       = mem_resp_i.b;
        buf_ready_o         = 1'b0;

        // Own writeback responses are swallowed here
        if (wb_hit) begin
            mem_req_o.b_ready   = 1'b1;
        end else begin
            mem_req_o.b_ready   = core_req_i.b_ready;
            core_resp_o.b_valid = mem_resp_i.b_valid;
        end

        case (w_state_q)
            W_PASS: begin
                mem_req_o.w_valid   = core_req_i.w_valid;
                core_resp_o.w_ready = mem_resp_i.w_ready;
            end
            W_BUF: begin
                mem_req_o.w       = buf_beat_i;
                mem_req_o.w_valid = buf_valid_i;
                buf_ready_o       = mem_resp_i.w_ready;
            end
            default: ;
        endcase

        w_hs = mem_req_o.w_valid && mem_resp_i.w_ready;

        w_state_d   = w_state_q;
        core_owed_d = core_owed_q;
        case (w_state_q)
            W_IDLE: begin
                if (aw_hs) begin
                    w_state_d = iss_aw_i.wb ? W_BUF : W_PASS;
                end
            end
            W_PASS: begin
                if (w_hs && core_req_i.w.last) begin
                    w_state_d = W_IDLE;
                end
            end
            W_BUF: begin
                if (aw_hs) begin
                    core_owed_d = 1'b1;
                end
                if (w_hs && buf_beat_i.last) begin
                    w_state_d   = (core_owed_q || aw_hs) ? W_PASS : W_IDLE;
                    core_owed_d = 1'b0;
                end
            end
            default: w_state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            w_state_q    <= W_IDLE;
            core_owed_q  <= 1'b0;
            wb_pending_q <= 1'b0;
            wb_id_q      <= '0;
        end else begin
            w_state_q   <= w_state_d;
            core_owed_q <= core_owed_d;
            if (wb_hit && mem_resp_i.b_valid) begin
                wb_pending_q <= 1'b0;
            end else if (aw_hs && iss_aw_i.wb) begin
                wb_pending_q <= 1'b1;
                wb_id_q      <= iss_aw_i.id;
            end
        end
    end

    assign wb_pending_o = wb_pending_q;
    assign wb_id_o      = wb_id_q;

endmodule

/* logic/ccu_mem_wb_buffer.sv */
`include "ccu_mem_settings.svh"

module ccu_mem_wb_buffer import ccu_mem_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,

    input  data_t  cd_data_i,
    input  logic   cd_valid_i,
    output logic   cd_full_o,

    output mem_w_t buf_beat_o,
    output logic   buf_valid_o,
    input  logic   buf_ready_i
);

    localparam int unsigned DEPTH  = `CCU_CD_DEPTH;
    localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W  = $clog2(DEPTH + 1);
    localparam int unsigned BEAT_W = (`CCU_LINE_WORDS > 1) ? $clog2(`CCU_LINE_WORDS) : 1;

    data_t            fifo_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [BEAT_W-1:0] beat_q;

    logic push, pop;

    assign cd_full_o   = (count_q == CNT_W'(DEPTH));
    assign buf_valid_o = (count_q != '0);
    assign push        = cd_valid_i && !cd_full_o;
    assign pop         = buf_valid_o && buf_ready_i;

    // Registered storage so a pushed word shows up on the next cycle
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= cd_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Popped beat position within the current line
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_q <= '0;
        end else if (pop) begin
            beat_q <= buf_beat_o.last ? '0 : beat_q + 1'b1;
        end
    end

    always_comb begin
        buf_beat_o.data = fifo_q[rd_ptr_q];
        buf_beat_o.strb = '1;
        buf_beat_o.last = (beat_q == BEAT_W'(`CCU_LINE_WORDS - 1));
    end

endmodule

/* logic/ccu_mem_ax_issuer.sv */
`include "ccu_mem_settings.svh"

module ccu_mem_ax_issuer import ccu_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,

    input  logic     cmd_valid_i,
    output logic     cmd_ready_o,
    input  mu_op_e   cmd_op_i,
    input  mem_req_t cmd_req_i,
    input  src_t     cmd_src_i,

    output mem_ax_t  iss_ar_o,
    output mem_ax_t  iss_aw_o,
    output logic     iss_ar_valid_o,
    output logic     iss_aw_valid_o,
    input  logic     iss_ar_ready_i,
    input  logic     iss_aw_ready_i,

    input  logic     wb_pending_i,
    input  mem_id_t  wb_id_i
);

    localparam int unsigned LINE_BYTES = `CCU_LINE_WORDS * `CCU_DATA_W / 8;
    localparam int unsigned BEAT_SIZE  = $clog2(`CCU_DATA_W / 8);

    typedef enum logic [1:0] {
        ISS_IDLE,
        ISS_WB_AW,
        ISS_AR,
        ISS_AW
    } iss_phase_e;

    iss_phase_e phase_q, phase_d;
    mu_op_e     op_q;

    mem_ax_t held_ar_q;
    mem_ax_t held_aw_q;
    src_t    held_src_q;

    mem_ax_t wb_base;
    mem_ax_t wb_ax;
    logic    core_aw_hold;
    logic    cmd_hs;

    assign cmd_ready_o = (phase_q == ISS_IDLE);
    assign cmd_hs      = cmd_valid_i && cmd_ready_o;

    // Held copy of the address channels of the command
    always_ff @(posedge clk_i) begin
        if (cmd_hs) begin
            held_ar_q  <= cmd_req_i.ar;
            held_aw_q  <= cmd_req_i.aw;
            held_src_q <= cmd_src_i;
        end
    end

    // Full line writeback derived from the held core request
    always_comb begin
        wb_base      = (op_q == OP_WB_WRITE) ? held_aw_q : held_ar_q;
        wb_ax        = '0;
        wb_ax.id     = {held_src_q, wb_base.id[`CCU_CORE_ID_W-1:0]};
        wb_ax.addr   = wb_base.addr & ~addr_t'(LINE_BYTES - 1);
        wb_ax.len    = 8'(`CCU_LINE_WORDS - 1);
        wb_ax.size   = 3'(BEAT_SIZE);
        wb_ax.wb     = 1'b1;
    end

    // Core write must not overtake a writeback with the same ID
    assign core_aw_hold = wb_pending_i && (wb_id_i == held_aw_q.id);

    always_comb begin
        iss_ar_o       = held_ar_q;
        iss_ar_valid_o = (phase_q == ISS_AR);
        iss_aw_o       = (phase_q == ISS_WB_AW) ? wb_ax : held_aw_q;
        iss_aw_valid_o = ((phase_q == ISS_WB_AW) && !wb_pending_i) ||
                         ((phase_q == ISS_AW) && !core_aw_hold);
    end

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            ISS_IDLE: begin
                if (cmd_valid_i) begin
                    case (cmd_op_i)
                        OP_READ:  phase_d = ISS_AR;
                        OP_WRITE: phase_d = ISS_AW;
                        default:  phase_d = ISS_WB_AW;
                    endcase
                end
            end
            ISS_WB_AW: begin
                if (iss_aw_valid_o && iss_aw_ready_i) begin
                    phase_d = (op_q == OP_WB_WRITE) ? ISS_AW : ISS_AR;
                end
            end
            ISS_AR: begin
                if (iss_ar_ready_i) begin
                    phase_d = ISS_IDLE;
                end
            end
            ISS_AW: begin
                if (iss_aw_valid_o && iss_aw_ready_i) begin
                    phase_d = ISS_IDLE;
                end
            end
            default: phase_d = ISS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            phase_q <= ISS_IDLE;
            op_q    <= OP_READ;
        end else begin
            phase_q <= phase_d;
            if (cmd_hs) begin
                op_q <= cmd_op_i;
            end
        end
    end

endmodule

/* logic/ccu_mem_pkg.sv */
`include "ccu_mem_settings.svh"

package ccu_mem_pkg;

    // Operations handed over by the control block
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_WB_READ,
        OP_WB_WRITE
    } mu_op_e;

    typedef logic [`CCU_ADDR_W-1:0]   addr_t;
    typedef logic [`CCU_DATA_W-1:0]   data_t;
    typedef logic [`CCU_DATA_W/8-1:0] strb_t;
    typedef logic [`CCU_MEM_ID_W-1:0] mem_id_t;
    typedef logic [`CCU_SRC_W-1:0]    src_t;

    // Address beat, shared by AR and AW
    typedef struct packed {
        mem_id_t    id;
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
        // Marks a line writeback issued by this unit
        logic       wb;
    } mem_ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } mem_w_t;

    typedef struct packed {
        mem_id_t    id;
        logic [1:0] resp;
    } mem_b_t;

    typedef struct packed {
        mem_id_t    id;
        data_t      data;
        logic [1:0] resp;
        logic       last;
    } mem_r_t;

    // Manager to subordinate direction
    typedef struct packed {
        mem_ax_t aw;
        logic    aw_valid;
        mem_w_t  w;
        logic    w_valid;
        logic    b_ready;
        mem_ax_t ar;
        logic    ar_valid;
        logic    r_ready;
    } mem_req_t;

    // Subordinate to manager direction
    typedef struct packed {
        logic   aw_ready;
        logic   w_ready;
        mem_b_t b;
        logic   b_valid;
        logic   ar_ready;
        mem_r_t r;
        logic   r_valid;
    } mem_resp_t;

endpackage

/* logic/ccu_mem_settings.svh */
`ifndef CCU_MEM_SETTINGS_SVH
`define CCU_MEM_SETTINGS_SVH

// Width of one data beat on the memory bus
`define CCU_DATA_W 64

// Beats per cache line
`define CCU_LINE_WORDS 4

// Core transaction ID and responder index widths
`define CCU_CORE_ID_W 4
`define CCU_SRC_W 2

// Memory side ID carries the responder index above the core ID
`define CCU_MEM_ID_W (`CCU_CORE_ID_W + `CCU_SRC_W)

// Depth of the snoop data FIFO
`define CCU_CD_DEPTH 2

`define CCU_ADDR_W 32

`endif
